// File: dv/tb_async_fifo.sv
`timescale 1ns/1ns

module tb_async_fifo import fifo_pkg::*; ();

  logic                  wr_clk;
  logic                  wr_rst_n;
  logic                  wr_en;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  full;
  logic                  afull;
  logic                  rd_clk;
  logic                  rd_rst_n;
  logic                  rd_en;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  empty;
  logic                  aempty;

  // Reference model state.
  logic [DATA_WIDTH-1:0] ref_q[$];
  int                    wr_count;
  int                    rd_count;
  logic                  rd_check;
  logic [DATA_WIDTH-1:0] rd_exp;
  logic                  rd_idle;
  logic [DATA_WIDTH-1:0] rd_hold;
  logic                  rst_check;
  logic                  fill_phase;
  logic                  drain_phase;
  int                    errors;
  int                    timeouts;
  integer                seed;
  integer                rd_seed;
  int                    n;

  async_fifo uut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .full     (full),
    .afull    (afull),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .empty    (empty),
    .aempty   (aempty)
  );

  initial begin
    wr_clk = 1'b0;
    forever #20 wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #28 rd_clk = ~rd_clk;
  end

  // Push side of the reference queue.
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      ref_q.push_back(wr_data);
      wr_count <= wr_count + 1;
    end
  end

  // Pop side. Expected word is checked on the next rd_clk edge.
  always @(posedge rd_clk) begin
    rd_check <= 1'b0;
    rd_idle  <= rd_rst_n && rd_en && empty;
    rd_hold  <= rd_data;
    if (rd_rst_n && rd_en && !empty) begin
      if (ref_q.size() > 0) begin
        rd_exp   <= ref_q.pop_front();
        rd_check <= 1'b1;
      end
      rd_count <= rd_count + 1;
    end
  end

  task automatic report_mismatch(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic report_timeout(input string msg);
    $display("Timeout at %0t: %s", $time, msg);
    timeouts++;
  endtask

  assert property (@(posedge wr_clk) rst_check |->
      empty && aempty && !full && !afull && rd_data == '0)
    else report_mismatch("flags or rd_data wrong after reset");

  assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      rd_check |-> rd_data == rd_exp)
    else report_mismatch("rd_data differs from reference queue");

  assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      rd_idle |-> rd_data == rd_hold)
    else report_mismatch("rd_data changed on a read while empty");

  assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      (wr_count - rd_count) >= FIFO_DEPTH |-> full)
    else report_mismatch("full low while reference queue is at depth");

  assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      (wr_count - rd_count) <= 0 |-> empty)
    else report_mismatch("empty low while reference queue is empty");

  // Flags are exact while only one side moves.
  assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      fill_phase |-> full == ((wr_count - rd_count) >= FIFO_DEPTH) &&
                     afull == ((wr_count - rd_count) >= AFULL_LEVEL))
    else report_mismatch("full or afull wrong during fill");

  assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      drain_phase |-> empty == ((wr_count - rd_count) == 0) &&
                      aempty == ((wr_count - rd_count) <= AEMPTY_LEVEL))
    else report_mismatch("empty or aempty wrong during drain");

  task automatic drive_random_writes(input int cycles);
    repeat (cycles) begin
      @(posedge wr_clk);
      #2;
      wr_en   = ($random(seed) & 7) < 5;
      wr_data = DATA_WIDTH'($random(seed));
    end
    @(posedge wr_clk);
    #2;
    wr_en = 1'b0;
  endtask

  task automatic drive_random_reads(input int cycles);
    repeat (cycles) begin
      @(posedge rd_clk);
      #2;
      rd_en = ($random(rd_seed) & 3) != 0;
    end
    @(posedge rd_clk);
    #2;
    rd_en = 1'b0;
  endtask

  task automatic drain_until_empty(input int limit);
    int cycles;
    cycles = 0;
    @(posedge rd_clk);
    #2;
    rd_en = 1'b1;
    while (!empty && cycles < limit) begin
      @(posedge rd_clk);
      #2;
      cycles++;
    end
    if (!empty) begin
      report_timeout("empty never rose while draining");
    end
    repeat (3) begin
      @(posedge rd_clk); // Reads that must be ignored.
      #2;
    end
    rd_en = 1'b0;
  endtask

  initial begin
    seed        = 32'h6654_c565;
    rd_seed     = $random(seed);
    wr_rst_n    = 1'b0;
    rd_rst_n    = 1'b0;
    wr_en       = 1'b0;
    wr_data     = '0;
    rd_en       = 1'b0;
    wr_count    = 0;
    rd_count    = 0;
    rd_check    = 1'b0;
    rd_exp      = '0;
    rd_idle     = 1'b0;
    rd_hold     = '0;
    rst_check   = 1'b0;
    fill_phase  = 1'b0;
    drain_phase = 1'b0;
    errors      = 0;
    timeouts    = 0;
    repeat (4) @(posedge wr_clk);
    #2;
    wr_rst_n  = 1'b1;
    rd_rst_n  = 1'b1;
    rst_check = 1'b1;
    @(posedge wr_clk);
    #2;
    rst_check = 1'b0;

    fork
      drive_random_writes(300);
      drive_random_reads(220);
    join
    repeat (4) @(posedge rd_clk); // Let the write pointer cross.
    drain_until_empty(24);

    // Single word into an empty FIFO.
    repeat (4) @(posedge wr_clk);
    #2;
    wr_en   = 1'b1;
    wr_data = DATA_WIDTH'($random(seed));
    @(posedge wr_clk);
    #2;
    wr_en = 1'b0;
    n = 0;
    while (empty && n < 4) begin
      @(posedge rd_clk);
      #1;
      n++;
    end
    if (empty) begin
      report_timeout("empty never fell after a write into an empty FIFO");
    end
    repeat (4) @(posedge rd_clk);
    drain_until_empty(8);

    // Fill with reads held off, then write into the full FIFO.
    repeat (4) @(posedge wr_clk);
    #2;
    fill_phase = 1'b1;
    wr_en      = 1'b1;
    wr_data    = DATA_WIDTH'($random(seed));
    n = 0;
    while (!full && n < 24) begin
      @(posedge wr_clk);
      #2;
      wr_data = DATA_WIDTH'($random(seed));
      n++;
    end
    if (!full) begin
      report_timeout("full never rose while filling");
    end
    repeat (6) begin
      @(posedge wr_clk);
      #2;
      wr_data = DATA_WIDTH'($random(seed)); // Dropped.
    end
    wr_en      = 1'b0;
    fill_phase = 1'b0;

    repeat (4) @(posedge rd_clk);
    #2;
    drain_phase = 1'b1;
    drain_until_empty(24);
    drain_phase = 1'b0;

    repeat (4) @(posedge rd_clk);
    $display("Checks finished: %0d value errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
hw/fifo_pkg.sv
hw/fifo_wr_ctrl.sv
hw/fifo_rd_ctrl.sv
hw/fifo_dp_ram.sv
hw/async_fifo.sv
dv/tb_async_fifo.sv

// File: hw/async_fifo.sv
`timescale 1ns/1ns

module async_fifo import fifo_pkg::*; (
  // Write side.
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  output logic                  full,
  output logic                  afull,
  // Read side.
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  empty,
  output logic                  aempty
);

  ram_wr_t   ram_wr;
  ram_rd_t   ram_rd;
  ptr_t      wr_ptr_gray; // Write domain to read domain.
  ptr_t      rd_ptr_gray; // Read domain to write domain.
  wr_flags_t wr_flags;
  rd_flags_t rd_flags;

  fifo_wr_ctrl u_wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .wr_data     (wr_data),
    .rd_ptr_gray (rd_ptr_gray),
    .ram_wr      (ram_wr),
    .wr_ptr_gray (wr_ptr_gray),
    .wr_flags    (wr_flags)
  );

  fifo_rd_ctrl u_rd_ctrl (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_gray (wr_ptr_gray),
    .ram_rd      (ram_rd),
    .rd_ptr_gray (rd_ptr_gray),
    .rd_flags    (rd_flags)
  );

  fifo_dp_ram u_dp_ram (
    .wr_clk   (wr_clk),
    .ram_wr   (ram_wr),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .ram_rd   (ram_rd),
    .rd_data  (rd_data)
  );

  assign full   = wr_flags.full;
  assign afull  = wr_flags.afull;
  assign empty  = rd_flags.empty;
  assign aempty = rd_flags.aempty;

endmodule

// File: hw/fifo_dp_ram.sv
`timescale 1ns/1ns

module fifo_dp_ram import fifo_pkg::*; (
  input  logic                  wr_clk,
  input  ram_wr_t               ram_wr,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  ram_rd_t               ram_rd,
  output logic [DATA_WIDTH-1:0] rd_data
);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  // Write port. The enable is already qualified by full.
  always_ff @(posedge wr_clk) begin
    if (ram_wr.en) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // Registered read port. Holds between reads.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (ram_rd.en) begin
      rd_data <= mem[ram_rd.addr];
    end
  end

endmodule

// File: hw/fifo_pkg.sv
package fifo_pkg;

  // FIFO geometry.
  localparam int DATA_WIDTH = 8;
  localparam int FIFO_DEPTH = 16;
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);
  localparam int PTR_WIDTH  = ADDR_WIDTH + 1; // Extra wrap bit.

  // Flag thresholds.
  localparam int AFULL_LEVEL  = FIFO_DEPTH - 1;
  localparam int AEMPTY_LEVEL = 1;

  typedef logic [PTR_WIDTH-1:0] ptr_t;

  typedef struct packed {
    logic                  en;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
  } ram_wr_t;

  typedef struct packed {
    logic                  en;
    logic [ADDR_WIDTH-1:0] addr;
  } ram_rd_t;

  typedef struct packed {
    logic full;
    logic afull;
  } wr_flags_t;

  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_flags_t;

  // Pointer code conversions used by both controllers.
  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[PTR_WIDTH-1] = gray[PTR_WIDTH-1];
    for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// File: hw/fifo_rd_ctrl.sv
`timescale 1ns/1ns

module fifo_rd_ctrl import fifo_pkg::*; (
  input  logic      rd_clk,
  input  logic      rd_rst_n,
  input  logic      rd_en,
  input  ptr_t      wr_ptr_gray,
  output ram_rd_t   ram_rd,
  output ptr_t      rd_ptr_gray,
  output rd_flags_t rd_flags
);

  ptr_t                 rd_ptr_bin;
  ptr_t                 rd_ptr_bin_nxt;
  ptr_t                 rd_ptr_gray_nxt;
  ptr_t                 wr_ptr_sync1;
  ptr_t                 wr_ptr_sync2;
  ptr_t                 wr_ptr_sync_bin;
  logic [PTR_WIDTH-1:0] rd_level;
  logic                 rd_accept;
  logic                 empty_nxt;
  logic                 aempty_nxt;

  // Reads from an empty FIFO are ignored.
  assign rd_accept = rd_en & ~rd_flags.empty;

  assign rd_ptr_bin_nxt  = rd_ptr_bin + ptr_t'(rd_accept);
  assign rd_ptr_gray_nxt = bin2gray(rd_ptr_bin_nxt);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr_bin  <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr_bin  <= rd_ptr_bin_nxt;
      rd_ptr_gray <= rd_ptr_gray_nxt; // Crosses to the write side.
    end
  end

  // Two-flop synchronizer on the write pointer.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_ptr_sync1 <= '0;
      wr_ptr_sync2 <= '0;
    end else begin
      wr_ptr_sync1 <= wr_ptr_gray;
      wr_ptr_sync2 <= wr_ptr_sync1;
    end
  end

  assign wr_ptr_sync_bin = gray2bin(wr_ptr_sync2);

  // Stale write pointer only understates the level.
  assign rd_level = wr_ptr_sync_bin - rd_ptr_bin_nxt;

  assign empty_nxt  = (rd_level == '0);
  assign aempty_nxt = (rd_level <= PTR_WIDTH'(AEMPTY_LEVEL));

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_flags.empty  <= 1'b1;
      rd_flags.aempty <= 1'b1;
    end else begin
      rd_flags.empty  <= empty_nxt;
      rd_flags.aempty <= aempty_nxt;
    end
  end

  // Memory read port.
  assign ram_rd.en   = rd_accept;
  assign ram_rd.addr = rd_ptr_bin[ADDR_WIDTH-1:0];

endmodule

// File: hw/fifo_wr_ctrl.sv
`timescale 1ns/1ns

module fifo_wr_ctrl import fifo_pkg::*; (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  ptr_t                  rd_ptr_gray,
  output ram_wr_t               ram_wr,
  output ptr_t                  wr_ptr_gray,
  output wr_flags_t             wr_flags
);

  ptr_t                 wr_ptr_bin;
  ptr_t                 wr_ptr_bin_nxt;
  ptr_t                 wr_ptr_gray_nxt;
  ptr_t                 rd_ptr_sync1;
  ptr_t                 rd_ptr_sync2;
  ptr_t                 rd_ptr_sync_bin;
  logic [PTR_WIDTH-1:0] wr_level;
  logic                 wr_accept;
  logic                 full_nxt;
  logic                 afull_nxt;

  // Writes into a full FIFO are dropped.
  assign wr_accept = wr_en & ~wr_flags.full;

  assign wr_ptr_bin_nxt  = wr_ptr_bin + ptr_t'(wr_accept);
  assign wr_ptr_gray_nxt = bin2gray(wr_ptr_bin_nxt);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr_bin  <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr_bin  <= wr_ptr_bin_nxt;
      wr_ptr_gray <= wr_ptr_gray_nxt; // Crosses to the read side.
    end
  end

  // Two-flop synchronizer on the read pointer.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_ptr_sync1 <= '0;
      rd_ptr_sync2 <= '0;
    end else begin
      rd_ptr_sync1 <= rd_ptr_gray;
      rd_ptr_sync2 <= rd_ptr_sync1;
    end
  end

  assign rd_ptr_sync_bin = gray2bin(rd_ptr_sync2);

  // Stale read pointer only overstates the level.
  assign wr_level = wr_ptr_bin_nxt - rd_ptr_sync_bin;

  assign full_nxt  = (wr_level >= PTR_WIDTH'(FIFO_DEPTH));
  assign afull_nxt = (wr_level >= PTR_WIDTH'(AFULL_LEVEL));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_flags.full  <= 1'b0;
      wr_flags.afull <= 1'b0;
    end else begin
      wr_flags.full  <= full_nxt;
      wr_flags.afull <= afull_nxt;
    end
  end

  // Memory write port.
  assign ram_wr.en   = wr_accept;
  assign ram_wr.addr = wr_ptr_bin[ADDR_WIDTH-1:0];
  assign ram_wr.data = wr_data;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the async FIFO testbench with Verilator.

cd "$(dirname "$0")" || exit 1

top=tb_async_fifo
log=sim.log

rm -rf obj_dir

verilator --binary --timing --assert --top-module "$top" -f filelist.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./obj_dir/V$top" > "$log" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status, see $log"
  exit 1
fi

if grep -q "^Test OK$" "$log"; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed, see $log"
exit 1
